/* list.f */
+incdir+src
src/mera_pkg.sv
src/power_seq.sv
src/bus_master.sv
src/mem_map.sv
src/sram_ctrl.sv
src/mem_elwro.sv
src/mera_sys.sv
sim/sram_model.sv
sim/tb_mera_sys.sv

/* run.sh */
#!/bin/sh
# build and run the MERA-400 memory bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -f list.f --top-module tb_mera_sys -o tb_mera_sys

./obj_dir/tb_mera_sys > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	exit 1
fi
exit 0

/* sim/tb_mera_sys.sv */
`timescale 1ns/100ps
`include "mera_cfg.svh"

module tb_mera_sys import mera_pkg::*; ();

	// one table row
	typedef struct {
		cyc_e kind;
		logic clr;
		nb_t nb;
		addr_t ad;
		word_t dt;
		word_t exp_dt;
		logic exp_alarm;
		int stall;
	} entry_t;

	logic clk;
	logic arst_n;
	logic dcl;
	bus_req_t req;
	logic req_valid;
	logic req_ready;
	bus_resp_t resp;
	logic resp_valid;
	logic resp_ready;
	sram_ctl_t sram_ctl;
	sram_addr_t sram_a;
	word_t sram_d_out;
	logic sram_d_oe;
	word_t sram_d_in;

	entry_t tbl[$];
	logic table_built;
	logic [31:0] lfsr;
	int errors;
	int test_err;

	// reference model
	logic ref_valid [256];
	frame_t ref_frame [256];
	word_t ref_mem [int];

	mera_sys UUT (
		.clk(clk),
		.arst_n(arst_n),
		.dcl(dcl),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.resp(resp),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.sram_ctl(sram_ctl),
		.sram_a(sram_a),
		.sram_d_out(sram_d_out),
		.sram_d_oe(sram_d_oe),
		.sram_d_in(sram_d_in)
	);

	sram_model sram (
		.ctl(sram_ctl),
		.a(sram_a),
		.d_in(sram_d_out),
		.d_oe(sram_d_oe),
		.d_out(sram_d_in)
	);

	always #5 clk = !clk;

	// ----------------------------------------
	// random source
	// ----------------------------------------

	// fibonacci, taps 32 22 2 1
	function automatic logic take_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic word_t rand_word();
		word_t w;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], take_bit()};
		end
		return w;
	endfunction

	// 1 to 8 cycles
	function automatic int rand_stall();
		logic [2:0] s;
		s = '0;
		for (int i = 0; i < 3; i++) begin
			s = {s[1:0], take_bit()};
		end
		return int'(s) + 1;
	endfunction

	// ----------------------------------------
	// reference model and table
	// ----------------------------------------

	// untouched sram words hold the fill pattern
	function automatic word_t ref_read(input int sa);
		if (ref_mem.exists(sa)) begin
			return ref_mem[sa];
		end
		return word_t'(sa) ^ {2'(sa >> 16), 14'(sa >> 4)};
	endfunction

	function automatic void ref_clear();
		for (int i = 0; i < 256; i++) begin
			ref_valid[i] = (i == 0);
			ref_frame[i] = '0;
		end
	endfunction

	// runs one request through the model and queues it
	function automatic void add(input cyc_e kind, input nb_t nb, input addr_t ad,
			input word_t dt, input int stall);
		entry_t e;
		int idx;
		int sa;
		idx = int'({nb, ad[15:12]});
		e.kind = kind;
		e.clr = 1'b0;
		e.nb = nb;
		e.ad = ad;
		e.dt = dt;
		e.exp_dt = '0;
		e.exp_alarm = 1'b0;
		e.stall = stall;
		if (kind == CYC_S) begin
			idx = int'({nb, dt[15:12]});
			// entry 0 is hard wired
			if (idx != 0) begin
				ref_valid[idx] = 1'b1;
				ref_frame[idx] = dt[5:0];
			end
		end else if (!ref_valid[idx]) begin
			e.exp_alarm = 1'b1;
		end else begin
			sa = int'({ref_frame[idx], ad[11:0]});
			if (kind == CYC_W) begin
				ref_mem[sa] = dt;
			end else begin
				e.exp_dt = ref_read(sa);
			end
		end
		tbl.push_back(e);
	endfunction

	function automatic void add_clear();
		entry_t e;
		e = '{CYC_R, 1'b1, '0, '0, '0, '0, 1'b0, 0};
		ref_clear();
		tbl.push_back(e);
	endfunction

	// config word: page on top, frame at the bottom
	function automatic word_t cfg(input page_t p, input frame_t f);
		return {p, 6'b0, f};
	endfunction

	function automatic void build_table();
		ref_clear();
		// block 0 page 0 without config
		add(CYC_W, 4'd0, 16'h0123, rand_word(), 0);
		add(CYC_R, 4'd0, 16'h0123, '0, 0);
		// unmapped pages
		add(CYC_R, 4'd0, 16'h1005, '0, 0);
		add(CYC_W, 4'd2, 16'h3000, rand_word(), 0);
		// two frames, plus an alias of frame 5
		add(CYC_S, 4'd0, '0, cfg(4'd1, 6'd5), 0);
		add(CYC_S, 4'd0, '0, cfg(4'd2, 6'd9), 0);
		add(CYC_S, 4'd0, '0, cfg(4'd3, 6'd5), 0);
		add(CYC_W, 4'd0, 16'h1010, rand_word(), 0);
		add(CYC_W, 4'd0, 16'h2010, rand_word(), 0);
		add(CYC_R, 4'd0, 16'h1010, '0, 0);
		add(CYC_R, 4'd0, 16'h2010, '0, 0);
		add(CYC_W, 4'd0, 16'h3020, rand_word(), 0);
		add(CYC_R, 4'd0, 16'h1020, '0, 0);
		// same page in another block
		add(CYC_S, 4'd1, '0, cfg(4'd1, 6'd12), 0);
		add(CYC_W, 4'd1, 16'h1010, rand_word(), 0);
		add(CYC_R, 4'd0, 16'h1010, '0, 0);
		add(CYC_R, 4'd1, 16'h1010, '0, 0);
		// clear drops the map, the sram keeps its words
		add_clear();
		add(CYC_R, 4'd0, 16'h1010, '0, 0);
		add(CYC_R, 4'd1, 16'h1010, '0, 0);
		add(CYC_R, 4'd0, 16'h0123, '0, 0);
		// response stalls
		for (int i = 0; i < 4; i++) begin
			add(CYC_W, 4'd0, 16'h0200 + addr_t'(i), rand_word(), rand_stall());
			add(CYC_R, 4'd0, 16'h0200 + addr_t'(i), '0, rand_stall());
		end
		add(CYC_R, 4'd2, 16'h3000, '0, rand_stall());
	endfunction

	// ----------------------------------------
	// checks and drivers
	// ----------------------------------------

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		dcl <= 1'b1;
		repeat (2) @(posedge clk);
		dcl <= 1'b0;
		do @(negedge clk); while (!clm_high());
		do @(negedge clk); while (clm_high());
	endtask

	function automatic logic clm_high();
		return UUT.clm;
	endfunction

	task automatic run_cycle(input entry_t e);
		bus_resp_t held;
		@(posedge clk);
		req <= '{e.kind, e.nb, e.ad, e.dt};
		req_valid <= 1'b1;
		do @(negedge clk); while (!req_ready);
		@(posedge clk);
		req_valid <= 1'b0;
		do @(negedge clk); while (!resp_valid);
		held = resp;
		check(32'(resp.dt), 32'(e.exp_dt), "response data");
		check(32'(resp.alarm), 32'(e.exp_alarm), "alarm flag");
		// held response must not move, no new request taken
		for (int i = 0; i < e.stall; i++) begin
			@(negedge clk);
			check(32'(resp), 32'(held), "resp during stall");
			check(32'(resp_valid), 32'd1, "resp_valid during stall");
			check(32'(req_ready), 32'd0, "req_ready during stall");
		end
		@(posedge clk);
		resp_ready <= 1'b1;
		do @(negedge clk); while (resp_valid);
		@(posedge clk);
		resp_ready <= 1'b0;
	endtask

	// ----------------------------------------
	// main flow
	// ----------------------------------------

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		dcl = 1'b0;
		req = '0;
		req_valid = 1'b0;
		resp_ready = 1'b0;
		lfsr = 32'haf49e8b9;
		errors = 0;
		table_built = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		do @(negedge clk); while (clm_high());
		foreach (tbl[n]) begin
			test_err = 0;
			if (tbl[n].clr) begin
				pulse_clear();
			end else begin
				run_cycle(tbl[n]);
			end
			$display("test %0d %s nb %0d ad %h: %s", n,
				tbl[n].clr ? "CLR" : tbl[n].kind.name(), tbl[n].nb, tbl[n].ad,
				(test_err == 0) ? "ok" : "FAILED");
		end
		$display("tests %0d errors %0d", tbl.size(), errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// budget per row covers the alarm wait plus handshakes
	initial begin
		wait (table_built);
		#(tbl.size() * (`MERA_ALARM_TICKS + 20) * 10);
		$display("timeout: the test table did not finish in time");
		$display("sim failed");
		$finish;
	end

endmodule

/* sim/sram_model.sv */
`timescale 1ns/100ps

module sram_model import mera_pkg::*; (
	input  sram_ctl_t  ctl,
	input  sram_addr_t a,
	input  word_t      d_in,
	input  logic       d_oe,
	output word_t      d_out
);

	// 256K words
	word_t mem [0:262143];
	logic ce_n;
	logic oe_n;
	logic we_n;
	// address, data and byte lanes seen while the write pulse is on
	sram_addr_t wr_a;
	word_t wr_d;
	logic wr_ub;
	logic wr_lb;
	// set once a real write pulse with driven data has been seen
	logic armed;
	word_t rd_word;

	assign ce_n = ctl.ce_n;
	assign oe_n = ctl.oe_n;
	assign we_n = ctl.we_n;

	// fill depends on every address bit
	initial begin
		armed = 1'b0;
		for (int i = 0; i < 262144; i++) begin
			mem[i] = word_t'(i) ^ {2'(i >> 16), 14'(i >> 4)};
		end
	end

	// follow the pins while ce, we and the data drivers are all on
	always @(ctl or a or d_in or d_oe) begin
		if (!ctl.ce_n && !ctl.we_n && d_oe) begin
			wr_a = a;
			wr_d = d_in;
			wr_ub = !ctl.ub_n;
			wr_lb = !ctl.lb_n;
			armed = 1'b1;
		end
	end

	// data taken at the end of the write pulse, as on the real part
	always @(posedge we_n) begin
		if (armed) begin
			if (wr_ub) begin
				mem[wr_a][15:8] <= wr_d[15:8];
			end
			if (wr_lb) begin
				mem[wr_a][7:0] <= wr_d[7:0];
			end
		end
	end

	// byte lanes gated, no drive while the controller holds the bus
	assign rd_word = mem[a];
	assign d_out = (!ce_n && !oe_n && !d_oe) ?
		{ctl.ub_n ? 8'h00 : rd_word[15:8], ctl.lb_n ? 8'h00 : rd_word[7:0]} : 16'h0000;

endmodule

/* src/mera_sys.sv */
`timescale 1ns/100ps

module mera_sys import mera_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       dcl,
	// cpu side request port
	input  bus_req_t   req,
	input  logic       req_valid,
	output logic       req_ready,
	output bus_resp_t  resp,
	output logic       resp_valid,
	input  logic       resp_ready,
	// sram
	output sram_ctl_t  sram_ctl,
	output sram_addr_t sram_a,
	output word_t      sram_d_out,
	output logic       sram_d_oe,
	input  word_t      sram_d_in
);

	// master clear, from power supply to everybody
	logic clm;
	// system bus
	sysbus_t bus;
	logic ok;
	word_t rdt;

	// ----------------------------------------
	// power supply
	// ----------------------------------------

	power_seq puks (
		.clk(clk),
		.arst_n(arst_n),
		.dcl(dcl),
		.clm(clm)
	);

	// ----------------------------------------
	// cpu bus drivers
	// ----------------------------------------

	bus_master master (
		.clk(clk),
		.arst_n(arst_n),
		.clm(clm),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.resp(resp),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.bus(bus),
		.ok(ok),
		.rdt(rdt)
	);

	// ----------------------------------------
	// memory
	// ----------------------------------------

	mem_elwro mem (
		.clk(clk),
		.arst_n(arst_n),
		.clm(clm),
		.bus(bus),
		.ok(ok),
		.rdt(rdt),
		.sram_ctl(sram_ctl),
		.sram_a(sram_a),
		.sram_d_out(sram_d_out),
		.sram_d_oe(sram_d_oe),
		.sram_d_in(sram_d_in)
	);

endmodule

/* src/mem_elwro.sv */
`timescale 1ns/100ps
`include "mera_cfg.svh"

module mem_elwro import mera_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       clm,
	// system bus
	input  sysbus_t    bus,
	output logic       ok,
	output word_t      rdt,
	// sram
	output sram_ctl_t  sram_ctl,
	output sram_addr_t sram_a,
	output word_t      sram_d_out,
	output logic       sram_d_oe,
	input  word_t      sram_d_in
);

	// previous strobe levels, so each strobe is served once
	logic w_q, r_q, s_q;
	logic w_rise, r_rise, s_rise;
	page_t page;
	logic [`MERA_OFFSET_BITS-1:0] offset;
	frame_t frame;
	logic hit;
	logic sram_start;
	logic sram_done;

	// ----------------------------------------
	// strobe decode
	// ----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			w_q <= 1'b0;
			r_q <= 1'b0;
			s_q <= 1'b0;
		end else begin
			w_q <= bus.w;
			r_q <= bus.r;
			s_q <= bus.s;
		end
	end

	assign w_rise = bus.w && !w_q;
	assign r_rise = bus.r && !r_q;
	assign s_rise = bus.s && !s_q;

	// top nibble selects the page
	assign page = bus.ad[15:12];
	assign offset = bus.ad[`MERA_OFFSET_BITS-1:0];

	// ----------------------------------------
	// segment map
	// ----------------------------------------

	// config word: page in dt[15:12], frame in dt[5:0]
	mem_map map (
		.clk(clk),
		.arst_n(arst_n),
		.clm(clm),
		.wr_en(s_rise),
		.wr_nb(bus.nb),
		.wr_page(bus.dt[15:12]),
		.wr_frame(bus.dt[5:0]),
		.rd_nb(bus.nb),
		.rd_page(page),
		.rd_frame(frame),
		.rd_hit(hit)
	);

	// ----------------------------------------
	// sram access
	// ----------------------------------------

	// unmapped page never starts, so never answers
	assign sram_start = (r_rise || w_rise) && hit;

	sram_ctrl sram (
		.clk(clk),
		.arst_n(arst_n),
		.start(sram_start),
		.we(bus.w),
		.addr({frame, offset}),
		.wdata(bus.dt),
		.done(sram_done),
		.rdata(rdt),
		.sram_ctl(sram_ctl),
		.sram_a(sram_a),
		.sram_d_out(sram_d_out),
		.sram_d_oe(sram_d_oe),
		.sram_d_in(sram_d_in)
	);

	// one-cycle ok, config right away, access after done
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ok <= 1'b0;
		end else if (clm) begin
			ok <= 1'b0;
		end else begin
			ok <= s_rise || sram_done;
		end
	end

endmodule

/* src/sram_ctrl.sv */
`timescale 1ns/100ps
`include "mera_cfg.svh"

module sram_ctrl import mera_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	// word access request
	input  logic       start,
	input  logic       we,
	input  sram_addr_t addr,
	input  word_t      wdata,
	output logic       done,
	output word_t      rdata,
	// sram pins
	output sram_ctl_t  sram_ctl,
	output sram_addr_t sram_a,
	output word_t      sram_d_out,
	output logic       sram_d_oe,
	input  word_t      sram_d_in
);

	localparam int unsigned CNT_W = $clog2(`MERA_SRAM_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MERA_SRAM_CYCLES - 1);

	ss_e state;
	logic [CNT_W-1:0] cnt;
	logic access;
	logic last;
	logic we_q;
	sram_addr_t addr_q;
	word_t wdata_q;

	assign access = (state == SS_ACCESS);
	assign last = access && (cnt == CNT_LAST);

	// ----------------------------------------
	// fsm
	// ----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= SS_IDLE;
			cnt <= '0;
		end else begin
			case (state)
			SS_IDLE: begin
				cnt <= '0;
				if (start) begin
					state <= SS_ACCESS;
				end
			end
			SS_ACCESS: begin
				if (last) begin
					state <= SS_FINISH;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			SS_FINISH: begin
				// done pulse, back to idle
				state <= SS_IDLE;
			end
			default: begin
				state <= SS_IDLE;
			end
			endcase
		end
	end

	// ----------------------------------------
	// address and data
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if ((state == SS_IDLE) && start) begin
			we_q <= we;
			addr_q <= addr;
			wdata_q <= wdata;
		end
		// read data settled by the last access cycle
		if (last && !we_q) begin
			rdata <= sram_d_in;
		end
	end

	assign done = (state == SS_FINISH);

	// word access, both byte lanes
	always_comb begin
		sram_ctl.ce_n = !access;
		sram_ctl.oe_n = !(access && !we_q);
		sram_ctl.we_n = !(access && we_q);
		sram_ctl.ub_n = !access;
		sram_ctl.lb_n = !access;
	end

	assign sram_a = addr_q;
	assign sram_d_out = wdata_q;
	// drive the data bus only while writing
	assign sram_d_oe = access && we_q;

endmodule

/* src/mem_map.sv */
`timescale 1ns/100ps
`include "mera_cfg.svh"

module mem_map import mera_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   clm,
	// config write
	input  logic   wr_en,
	input  nb_t    wr_nb,
	input  page_t  wr_page,
	input  frame_t wr_frame,
	// lookup
	input  nb_t    rd_nb,
	input  page_t  rd_page,
	output frame_t rd_frame,
	output logic   rd_hit
);

	localparam int unsigned IDX_W = $clog2(`MERA_MAP_ENTRIES);

	// entry index is block then page
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	frame_t frames [`MERA_MAP_ENTRIES];
	logic [`MERA_MAP_ENTRIES-1:0] valid;

	assign wr_idx = {wr_nb, wr_page};
	assign rd_idx = {rd_nb, rd_page};

	// ----------------------------------------
	// valid bits
	// ----------------------------------------

	// block 0 page 0 always present
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= `MERA_MAP_ENTRIES'(1);
		end else if (clm) begin
			valid <= `MERA_MAP_ENTRIES'(1);
		end else if (wr_en && (wr_idx != '0)) begin
			valid[wr_idx] <= 1'b1;
		end
	end

	// ----------------------------------------
	// frame table
	// ----------------------------------------

	// entry 0 is rewired to frame 0 on clear, never by config
	always_ff @(posedge clk) begin
		if (clm) begin
			frames[0] <= '0;
		end else if (wr_en && (wr_idx != '0)) begin
			frames[wr_idx] <= wr_frame;
		end
	end

	// lookup is combinational, same cycle as the strobe edge
	assign rd_frame = frames[rd_idx];
	assign rd_hit = valid[rd_idx];

endmodule

/* src/bus_master.sv */
`timescale 1ns/100ps
`include "mera_cfg.svh"

module bus_master import mera_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      clm,
	// request port
	input  bus_req_t  req,
	input  logic      req_valid,
	output logic      req_ready,
	// response port
	output bus_resp_t resp,
	output logic      resp_valid,
	input  logic      resp_ready,
	// system bus
	output sysbus_t   bus,
	input  logic      ok,
	input  word_t     rdt
);

	localparam int unsigned ALARM_W = $clog2(`MERA_ALARM_TICKS + 1);
	localparam logic [ALARM_W-1:0] ALARM_LAST = ALARM_W'(`MERA_ALARM_TICKS - 1);

	ms_e state;
	bus_req_t req_q;
	bus_resp_t resp_q;
	logic [ALARM_W-1:0] alarm_cnt;
	logic req_fire;
	logic alarm_hit;

	// new request only when idle and out of clear
	assign req_ready = (state == MS_IDLE) && !clm;
	assign req_fire = req_valid && req_ready;
	// last strobe cycle without ok
	assign alarm_hit = (alarm_cnt == ALARM_LAST);

	// ----------------------------------------
	// fsm
	// ----------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= MS_IDLE;
			alarm_cnt <= '0;
		end else if (clm) begin
			// clear drops whatever cycle is going on
			state <= MS_IDLE;
			alarm_cnt <= '0;
		end else begin
			case (state)
			MS_IDLE: begin
				alarm_cnt <= '0;
				if (req_fire) begin
					state <= MS_STROBE;
				end
			end
			MS_STROBE: begin
				// ok wins over a timeout in the same cycle
				if (ok || alarm_hit) begin
					state <= MS_RELEASE;
				end else begin
					alarm_cnt <= alarm_cnt + 1'b1;
				end
			end
			MS_RELEASE: begin
				// strobe is down here, response already valid
				if (resp_ready) begin
					state <= MS_IDLE;
				end else begin
					state <= MS_RESPOND;
				end
			end
			MS_RESPOND: begin
				if (resp_ready) begin
					state <= MS_IDLE;
				end
			end
			default: begin
				state <= MS_IDLE;
			end
			endcase
		end
	end

	// ----------------------------------------
	// request and response words
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (req_fire) begin
			req_q <= req;
		end
		if (state == MS_STROBE) begin
			if (ok) begin
				// only a read brings data back
				resp_q.dt <= (req_q.kind == CYC_R) ? rdt : '0;
				resp_q.alarm <= 1'b0;
			end else if (alarm_hit) begin
				// awaria: no memory answered
				resp_q.dt <= '0;
				resp_q.alarm <= 1'b1;
			end
		end
	end

	assign resp = resp_q;
	assign resp_valid = (state == MS_RELEASE) || (state == MS_RESPOND);

	// one strobe, matching the kind, only while in strobe state
	always_comb begin
		bus.w = (state == MS_STROBE) && (req_q.kind == CYC_W);
		bus.r = (state == MS_STROBE) && (req_q.kind == CYC_R);
		bus.s = (state == MS_STROBE) && (req_q.kind == CYC_S);
		bus.nb = req_q.nb;
		bus.ad = req_q.ad;
		bus.dt = req_q.dt;
	end

endmodule

/* src/power_seq.sv */
`timescale 1ns/100ps
`include "mera_cfg.svh"

module power_seq (
	input  logic clk,
	input  logic arst_n,
	input  logic dcl,
	output logic clm
);

	localparam int unsigned CNT_W = $clog2(`MERA_CLM_TICKS + 1);
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`MERA_CLM_TICKS);

	// dcl sync chain, last stage only for edge detect
	logic [2:0] dcl_sr;
	logic dcl_rise;
	logic [CNT_W-1:0] clm_cnt;

	// ----------------------------------------
	// clear request input
	// ----------------------------------------

	// panel button is asynchronous to clk
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dcl_sr <= '0;
		end else begin
			dcl_sr <= {dcl_sr[1:0], dcl};
		end
	end

	assign dcl_rise = dcl_sr[1] && !dcl_sr[2];

	// ----------------------------------------
	// clm pulse
	// ----------------------------------------

	// counter starts loaded, so clm is up right out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clm_cnt <= CNT_LOAD;
		end else if (dcl_rise) begin
			clm_cnt <= CNT_LOAD;
		end else if (clm_cnt != '0) begin
			clm_cnt <= clm_cnt - 1'b1;
		end
	end

	// high while counting down
	assign clm = (clm_cnt != '0);

endmodule

/* src/mera_pkg.sv */
package mera_pkg;

	// ----------------------------------------
	// widths with a meaning
	// ----------------------------------------

	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;
	// block number (nb) and logical page
	typedef logic [3:0] nb_t;
	typedef logic [3:0] page_t;
	// physical 4K-word frame of the sram
	typedef logic [5:0] frame_t;
	// frame and 12-bit offset
	typedef logic [17:0] sram_addr_t;

	// bus cycle kind: read, write, memory config
	typedef enum logic [1:0] {
		CYC_R,
		CYC_W,
		CYC_S
	} cyc_e;

	// ----------------------------------------
	// port groups
	// ----------------------------------------

	// one word request from the cpu side
	typedef struct packed {
		cyc_e kind;
		nb_t nb;
		addr_t ad;
		word_t dt;
	} bus_req_t;

	typedef struct packed {
		word_t dt;
		logic alarm;
	} bus_resp_t;

	// master to memory lines, strobes active high
	typedef struct packed {
		logic w;
		logic r;
		logic s;
		nb_t nb;
		addr_t ad;
		word_t dt;
	} sysbus_t;

	// sram strobes, all active low
	typedef struct packed {
		logic ce_n;
		logic oe_n;
		logic we_n;
		logic ub_n;
		logic lb_n;
	} sram_ctl_t;

	// bus master fsm
	typedef enum logic [1:0] {
		MS_IDLE,
		MS_STROBE,
		MS_RELEASE,
		MS_RESPOND
	} ms_e;

	// sram controller fsm
	typedef enum logic [1:0] {
		SS_IDLE,
		SS_ACCESS,
		SS_FINISH
	} ss_e;

endpackage

/* src/mera_cfg.svh */
`ifndef MERA_CFG_SVH
`define MERA_CFG_SVH

// ----------------------------------------
// timing
// ----------------------------------------

// clock cycles the sram strobes are held for one word
`define MERA_SRAM_CYCLES 2

// cycles without ok before the master gives up (awaria)
`define MERA_ALARM_TICKS 16

// length of the master clear pulse
`define MERA_CLM_TICKS 8

// ----------------------------------------
// sizes
// ----------------------------------------

// offset bits inside one 4K-word page
`define MERA_OFFSET_BITS 12

// number of segment map entries, block x page
`define MERA_MAP_ENTRIES 256

`endif
